// ==== design/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Opcodes. Codes 8 to 15 execute as no-ops.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [3:0] {
        OP_NAND = 4'd0,
        OP_ADD  = 4'd1,
        OP_SHR  = 4'd2,
        OP_LDI  = 4'd3,
        OP_LD   = 4'd4,
        OP_ST   = 4'd5,
        OP_BR   = 4'd6,
        OP_HALT = 4'd7
    } opcode_e;

    // Register format, used by the ex and mem instructions.
    typedef struct packed {
        opcode_e    op;
        logic [2:0] rd;
        logic [2:0] ra;
        logic [2:0] rt;
        logic [1:0] rs;
        logic       spare;
    } r_fmt_t;

    // Immediate format for LDI. The immediate is zero-extended.
    typedef struct packed {
        opcode_e    op;
        logic [2:0] rd;
        logic [8:0] imm;
    } i_fmt_t;

    // Branch format. rw receives the link, rt holds the target.
    typedef struct packed {
        opcode_e    op;
        logic [2:0] rw;
        logic [2:0] rt;
        logic [1:0] rs;
        logic [2:0] spare;
        logic       invert;
    } b_fmt_t;

    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        b_fmt_t b;
    } instr_u;

endpackage

// ==== design/cpu_bus_pkg.sv ====
package cpu_bus_pkg;

    localparam int NUM_D_REG  = 8;
    localparam int NUM_S_REG  = 4;
    localparam int IMEM_WORDS = 64;
    localparam int DMEM_WORDS = 32;

    typedef logic [$clog2(NUM_D_REG)-1:0]  d_addr_t;
    typedef logic [$clog2(NUM_S_REG)-1:0]  s_addr_t;
    typedef logic [$clog2(DMEM_WORDS)-1:0] dmem_addr_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register file ports
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef struct packed {
        d_addr_t addr;
    } d_read_req_t;

    typedef struct packed {
        s_addr_t addr;
    } s_read_req_t;

    typedef struct packed {
        logic        valid;
        d_addr_t     addr;
        logic [15:0] data;
    } d_write_t;

    typedef struct packed {
        logic    valid;
        s_addr_t addr;
        logic    data;
    } s_write_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB host port and address map
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam logic [11:0] ADDR_CTRL      = 12'h000;
    localparam logic [11:0] ADDR_PC        = 12'h004;
    localparam logic [11:0] ADDR_DREG_BASE = 12'h040;
    localparam logic [11:0] ADDR_IMEM_BASE = 12'h100;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic        pready;
        logic [31:0] prdata;
        logic        pslverr;
    } apb_rsp_t;

endpackage

// ==== design/regfile.sv ====
module regfile (
    input  logic                     clk,
    input  logic                     n_rst,

    input  cpu_bus_pkg::d_read_req_t ex_ra,
    input  cpu_bus_pkg::d_read_req_t ex_rt,
    input  cpu_bus_pkg::d_read_req_t br_rt,
    input  cpu_bus_pkg::d_read_req_t mem_ra,
    input  cpu_bus_pkg::d_read_req_t mem_rt,
    input  cpu_bus_pkg::d_read_req_t host_rd,
    input  cpu_bus_pkg::s_read_req_t br_rs,

    output logic [15:0]              ex_ra_data,
    output logic [15:0]              ex_rt_data,
    output logic [15:0]              br_rt_data,
    output logic [15:0]              mem_ra_data,
    output logic [15:0]              mem_rt_data,
    output logic [15:0]              host_rd_data,
    output logic                     br_rs_data,

    input  cpu_bus_pkg::d_write_t    ex_rw,
    input  cpu_bus_pkg::d_write_t    br_rw,
    input  cpu_bus_pkg::d_write_t    mem_rw,
    input  cpu_bus_pkg::s_write_t    ex_rs
);

    logic [15:0] d_regs [cpu_bus_pkg::NUM_D_REG];
    logic        s_regs [cpu_bus_pkg::NUM_S_REG];

    always_comb begin
        ex_ra_data   = d_regs[ex_ra.addr];
        ex_rt_data   = d_regs[ex_rt.addr];
        br_rt_data   = d_regs[br_rt.addr];
        mem_ra_data  = d_regs[mem_ra.addr];
        mem_rt_data  = d_regs[mem_rt.addr];
        host_rd_data = d_regs[host_rd.addr];
        br_rs_data   = s_regs[br_rs.addr];
    end

    // The later assignment wins, so the order below gives mem over br over ex.
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            d_regs <= '{default: '0};
            s_regs <= '{default: '0};
        end else begin
            if (ex_rw.valid) begin
                d_regs[ex_rw.addr] <= ex_rw.data;
            end
            if (br_rw.valid) begin
                d_regs[br_rw.addr] <= br_rw.data;
            end
            if (mem_rw.valid) begin
                d_regs[mem_rw.addr] <= mem_rw.data;
            end
            if (ex_rs.valid) begin
                s_regs[ex_rs.addr] <= ex_rs.data;
            end
        end
    end

endmodule

// ==== design/exec_unit.sv ====
module exec_unit (
    input  logic                     go,
    input  cpu_isa_pkg::instr_u      instr,
    output cpu_bus_pkg::d_read_req_t ex_ra,
    output cpu_bus_pkg::d_read_req_t ex_rt,
    input  logic [15:0]              ex_ra_data,
    input  logic [15:0]              ex_rt_data,
    output cpu_bus_pkg::d_write_t    ex_rw,
    output cpu_bus_pkg::s_write_t    ex_rs
);

    logic [15:0] result;
    logic        writes_d;
    logic        writes_s;

    assign ex_ra.addr = instr.r.ra;
    assign ex_rt.addr = instr.r.rt;

    always_comb begin
        result   = '0;
        writes_d = 1'b0;
        writes_s = 1'b0;
        case (instr.r.op)
            cpu_isa_pkg::OP_NAND: begin
                result   = ~(ex_ra_data & ex_rt_data);
                writes_d = 1'b1;
                writes_s = 1'b1;
            end
            cpu_isa_pkg::OP_ADD: begin
                result   = ex_ra_data + ex_rt_data;
                writes_d = 1'b1;
                writes_s = 1'b1;
            end
            cpu_isa_pkg::OP_SHR: begin
                result   = ex_ra_data >> ex_rt_data[3:0];
                writes_d = 1'b1;
                writes_s = 1'b1;
            end
            cpu_isa_pkg::OP_LDI: begin
                result   = {7'd0, instr.i.imm};
                writes_d = 1'b1;
            end
            default: begin
            end
        endcase

        ex_rw.valid = go && writes_d;
        ex_rw.addr  = instr.r.rd;
        ex_rw.data  = result;

        // Zero flag.
        ex_rs.valid = go && writes_s;
        ex_rs.addr  = instr.r.rs;
        ex_rs.data  = (result == 16'd0);
    end

endmodule

// ==== design/branch_unit.sv ====
module branch_unit (
    input  logic                     go,
    input  cpu_isa_pkg::instr_u      instr,
    input  logic [5:0]               pc,
    output cpu_bus_pkg::d_read_req_t br_rt,
    output cpu_bus_pkg::s_read_req_t br_rs,
    input  logic [15:0]              br_rt_data,
    input  logic                     br_rs_data,
    output cpu_bus_pkg::d_write_t    br_rw,
    output logic                     taken,
    output logic [5:0]               target
);

    logic [5:0] link_pc;

    assign br_rt.addr = instr.b.rt;
    assign br_rs.addr = instr.b.rs;

    // The condition is the selected status flag, optionally inverted.
    assign taken  = go && (br_rs_data ^ instr.b.invert);
    assign target = br_rt_data[5:0];

    assign link_pc = pc + 6'd1;

    // The link is written on both outcomes. r0 as rw means no link.
    always_comb begin
        br_rw.valid = go && (instr.b.rw != '0);
        br_rw.addr  = instr.b.rw;
        br_rw.data  = {10'd0, link_pc};
    end

endmodule

// ==== design/mem_unit.sv ====
module mem_unit (
    input  logic                     clk,
    input  logic                     n_rst,
    input  logic                     go,
    input  cpu_isa_pkg::instr_u      instr,
    output cpu_bus_pkg::d_read_req_t mem_ra,
    output cpu_bus_pkg::d_read_req_t mem_rt,
    input  logic [15:0]              mem_ra_data,
    input  logic [15:0]              mem_rt_data,
    output cpu_bus_pkg::d_write_t    mem_rw
);

    logic [15:0]             dmem [cpu_bus_pkg::DMEM_WORDS];
    cpu_bus_pkg::dmem_addr_t eff_addr;
    logic                    do_load;
    logic                    do_store;

    assign mem_ra.addr = instr.r.ra;
    assign mem_rt.addr = instr.r.rt;

    // Truncation of ra gives the address modulo the memory size.
    assign eff_addr = cpu_bus_pkg::dmem_addr_t'(mem_ra_data);

    assign do_load  = go && (instr.r.op == cpu_isa_pkg::OP_LD);
    assign do_store = go && (instr.r.op == cpu_isa_pkg::OP_ST);

    always_comb begin
        mem_rw.valid = do_load;
        mem_rw.addr  = instr.r.rd;
        mem_rw.data  = dmem[eff_addr];
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            dmem <= '{default: '0};
        end else if (do_store) begin
            dmem[eff_addr] <= mem_rt_data;
        end
    end

endmodule

// ==== design/issue_ctrl.sv ====
module issue_ctrl (
    input  logic                clk,
    input  logic                n_rst,
    input  logic                start,
    input  logic                imem_we,
    input  logic [5:0]          imem_idx,
    input  logic [15:0]         imem_word,
    input  logic                taken,
    input  logic [5:0]          target,
    output cpu_isa_pkg::instr_u instr,
    output logic                ex_go,
    output logic                br_go,
    output logic                mem_go,
    output logic [5:0]          pc,
    output logic                running,
    output logic                halted
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUNNING,
        ST_HALTED
    } state_e;

    state_e      state;
    logic [15:0] imem [cpu_bus_pkg::IMEM_WORDS];
    logic        is_halt;

    always_ff @(posedge clk) begin
        if (imem_we) begin
            imem[imem_idx] <= imem_word;
        end
    end

    assign instr   = imem[pc];
    assign running = (state == ST_RUNNING);
    assign halted  = (state == ST_HALTED);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Decode to a single unit enable
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        ex_go   = 1'b0;
        br_go   = 1'b0;
        mem_go  = 1'b0;
        is_halt = 1'b0;
        if (running) begin
            case (instr.r.op)
                cpu_isa_pkg::OP_NAND,
                cpu_isa_pkg::OP_ADD,
                cpu_isa_pkg::OP_SHR,
                cpu_isa_pkg::OP_LDI:  ex_go   = 1'b1;
                cpu_isa_pkg::OP_LD,
                cpu_isa_pkg::OP_ST:   mem_go  = 1'b1;
                cpu_isa_pkg::OP_BR:   br_go   = 1'b1;
                cpu_isa_pkg::OP_HALT: is_halt = 1'b1;
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!n_rst) begin
            state <= ST_IDLE;
            pc    <= '0;
        end else begin
            case (state)
                ST_RUNNING: begin
                    // pc stays on the HALT so the host can read its address.
                    if (is_halt) begin
                        state <= ST_HALTED;
                    end else begin
                        pc <= taken ? target : pc + 6'd1;
                    end
                end
                default: begin
                    if (start) begin
                        state <= ST_RUNNING;
                        pc    <= '0;
                    end
                end
            endcase
        end
    end

endmodule

// ==== design/host_apb.sv ====
module host_apb (
    input  logic                     clk,
    input  logic                     n_rst,
    input  cpu_bus_pkg::apb_req_t    apb_req,
    output cpu_bus_pkg::apb_rsp_t    apb_rsp,
    output logic                     start,
    output logic                     imem_we,
    output logic [5:0]               imem_idx,
    output logic [15:0]              imem_word,
    input  logic                     running,
    input  logic                     halted,
    input  logic [5:0]               pc,
    output cpu_bus_pkg::d_read_req_t host_rd,
    input  logic [15:0]              host_rd_data
);

    logic        setup;
    logic        access;
    logic        ctrl_hit;
    logic        pc_hit;
    logic        dreg_hit;
    logic        imem_hit;
    logic [11:0] dreg_off;
    logic [11:0] imem_off;
    logic        err;
    logic [31:0] rd_data;
    logic        err_q;
    logic [31:0] prdata_q;
    logic        wr_ok;

    assign setup  = apb_req.psel && !apb_req.penable;
    assign access = apb_req.psel && apb_req.penable;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign dreg_off = apb_req.paddr - cpu_bus_pkg::ADDR_DREG_BASE;
    assign imem_off = apb_req.paddr - cpu_bus_pkg::ADDR_IMEM_BASE;

    assign ctrl_hit = (apb_req.paddr == cpu_bus_pkg::ADDR_CTRL);
    assign pc_hit   = (apb_req.paddr == cpu_bus_pkg::ADDR_PC);
    assign dreg_hit = (apb_req.paddr >= cpu_bus_pkg::ADDR_DREG_BASE)
                   && (dreg_off < 12'(4 * cpu_bus_pkg::NUM_D_REG))
                   && (apb_req.paddr[1:0] == 2'b00);
    assign imem_hit = (apb_req.paddr >= cpu_bus_pkg::ADDR_IMEM_BASE)
                   && (imem_off < 12'(4 * cpu_bus_pkg::IMEM_WORDS))
                   && (apb_req.paddr[1:0] == 2'b00);

    assign host_rd.addr = cpu_bus_pkg::d_addr_t'(dreg_off >> 2);

    always_comb begin
        rd_data = '0;
        err     = 1'b0;
        if (ctrl_hit) begin
            rd_data = {30'd0, halted, running};
        end else if (pc_hit) begin
            err     = apb_req.pwrite;
            rd_data = {26'd0, pc};
        end else if (dreg_hit) begin
            err     = apb_req.pwrite;
            rd_data = {16'd0, host_rd_data};
        end else if (imem_hit) begin
            err = !apb_req.pwrite || running;
        end else begin
            err = 1'b1;
        end
    end

    // Response is captured in the setup phase and presented in the access phase.
    always_ff @(posedge clk) begin
        if (!n_rst) begin
            err_q    <= 1'b0;
            prdata_q <= '0;
        end else if (setup) begin
            err_q    <= err;
            prdata_q <= apb_req.pwrite ? 32'd0 : rd_data;
        end else if (!apb_req.psel) begin
            err_q    <= 1'b0;
            prdata_q <= '0;
        end
    end

    assign apb_rsp.pready  = 1'b1;
    assign apb_rsp.prdata  = prdata_q;
    assign apb_rsp.pslverr = err_q;

    // A flagged access leaves all state untouched.
    assign wr_ok     = access && apb_req.pwrite && !err_q;
    assign start     = wr_ok && ctrl_hit && apb_req.pwdata[0];
    assign imem_we   = wr_ok && imem_hit;
    assign imem_idx  = 6'(imem_off >> 2);
    assign imem_word = apb_req.pwdata[15:0];

endmodule

// ==== design/nand_cpu.sv ====
module nand_cpu (
    input  logic                  clk,
    input  logic                  n_rst,
    input  cpu_bus_pkg::apb_req_t apb_req,
    output cpu_bus_pkg::apb_rsp_t apb_rsp
);

    logic                     start;
    logic                     imem_we;
    logic [5:0]               imem_idx;
    logic [15:0]              imem_word;
    logic                     running;
    logic                     halted;
    logic [5:0]               pc;
    cpu_isa_pkg::instr_u      instr;
    logic                     ex_go;
    logic                     br_go;
    logic                     mem_go;
    logic                     taken;
    logic [5:0]               target;

    cpu_bus_pkg::d_read_req_t host_rd;
    cpu_bus_pkg::d_read_req_t ex_ra;
    cpu_bus_pkg::d_read_req_t ex_rt;
    cpu_bus_pkg::d_read_req_t br_rt;
    cpu_bus_pkg::d_read_req_t mem_ra;
    cpu_bus_pkg::d_read_req_t mem_rt;
    cpu_bus_pkg::s_read_req_t br_rs;
    logic [15:0]              host_rd_data;
    logic [15:0]              ex_ra_data;
    logic [15:0]              ex_rt_data;
    logic [15:0]              br_rt_data;
    logic [15:0]              mem_ra_data;
    logic [15:0]              mem_rt_data;
    logic                     br_rs_data;
    cpu_bus_pkg::d_write_t    ex_rw;
    cpu_bus_pkg::d_write_t    br_rw;
    cpu_bus_pkg::d_write_t    mem_rw;
    cpu_bus_pkg::s_write_t    ex_rs;

    host_apb host_apb_i (
        .clk(clk), .n_rst(n_rst), .apb_req(apb_req), .apb_rsp(apb_rsp),
        .start(start), .imem_we(imem_we), .imem_idx(imem_idx), .imem_word(imem_word),
        .running(running), .halted(halted), .pc(pc),
        .host_rd(host_rd), .host_rd_data(host_rd_data)
    );

    issue_ctrl issue_ctrl_i (
        .clk(clk), .n_rst(n_rst), .start(start),
        .imem_we(imem_we), .imem_idx(imem_idx), .imem_word(imem_word),
        .taken(taken), .target(target), .instr(instr),
        .ex_go(ex_go), .br_go(br_go), .mem_go(mem_go),
        .pc(pc), .running(running), .halted(halted)
    );

    exec_unit exec_unit_i (
        .go(ex_go), .instr(instr), .ex_ra(ex_ra), .ex_rt(ex_rt),
        .ex_ra_data(ex_ra_data), .ex_rt_data(ex_rt_data),
        .ex_rw(ex_rw), .ex_rs(ex_rs)
    );

    branch_unit branch_unit_i (
        .go(br_go), .instr(instr), .pc(pc), .br_rt(br_rt), .br_rs(br_rs),
        .br_rt_data(br_rt_data), .br_rs_data(br_rs_data),
        .br_rw(br_rw), .taken(taken), .target(target)
    );

    mem_unit mem_unit_i (
        .clk(clk), .n_rst(n_rst), .go(mem_go), .instr(instr),
        .mem_ra(mem_ra), .mem_rt(mem_rt),
        .mem_ra_data(mem_ra_data), .mem_rt_data(mem_rt_data), .mem_rw(mem_rw)
    );

    regfile regfile_i (
        .clk(clk), .n_rst(n_rst),
        .ex_ra(ex_ra), .ex_rt(ex_rt), .br_rt(br_rt),
        .mem_ra(mem_ra), .mem_rt(mem_rt), .host_rd(host_rd), .br_rs(br_rs),
        .ex_ra_data(ex_ra_data), .ex_rt_data(ex_rt_data), .br_rt_data(br_rt_data),
        .mem_ra_data(mem_ra_data), .mem_rt_data(mem_rt_data),
        .host_rd_data(host_rd_data), .br_rs_data(br_rs_data),
        .ex_rw(ex_rw), .br_rw(br_rw), .mem_rw(mem_rw), .ex_rs(ex_rs)
    );

endmodule

// ==== test/nand_cpu_tb.sv ====
module nand_cpu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        logic [7:0][15:0] prog;
        logic [2:0]       reg_idx;
        logic [15:0]      expected;
        logic             use_model;
    } test_entry_t;

    logic                  clk;
    logic                  n_rst;
    cpu_bus_pkg::apb_req_t apb_req;
    cpu_bus_pkg::apb_rsp_t apb_rsp;

    test_entry_t tests [$];
    logic [31:0] rng;
    int          n_checks;
    int          n_mismatch;
    int          n_timeout;

    // Reference model state, kept across programs like the core's own state.
    logic [15:0] m_d   [8];
    logic        m_s   [4];
    logic [15:0] m_mem [32];
    logic [5:0]  m_pc;

    nand_cpu nand_cpu_i (
        .clk(clk), .n_rst(n_rst), .apb_req(apb_req), .apb_rsp(apb_rsp)
    );

    always #10 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Instruction encoding and random operands
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [15:0] r_word(input logic [3:0] op, input logic [2:0] rd,
                                           input logic [2:0] ra, input logic [2:0] rt,
                                           input logic [1:0] rs);
        return {op, rd, ra, rt, rs, 1'b0};
    endfunction

    function automatic logic [15:0] i_word(input logic [2:0] rd, input logic [8:0] imm);
        return {4'(cpu_isa_pkg::OP_LDI), rd, imm};
    endfunction

    function automatic logic [15:0] b_word(input logic [2:0] rw, input logic [2:0] rt,
                                           input logic [1:0] rs, input logic invert);
        return {4'(cpu_isa_pkg::OP_BR), rw, rt, rs, 3'b000, invert};
    endfunction

    function automatic logic [15:0] halt_word();
        return {4'(cpu_isa_pkg::OP_HALT), 12'h000};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [8:0] next_imm();
        rng = xorshift(rng);
        return rng[8:0];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        n_checks++;
        if (got !== exp) begin
            $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
            n_mismatch++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // APB driver
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic bus_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int waited;
        rdata = '0;
        err   = 1'b0;
        @(negedge clk);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = write;
        apb_req.paddr   = addr;
        apb_req.pwdata  = wdata;
        @(negedge clk);
        apb_req.penable = 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (!apb_rsp.pready && waited < 10);
        if (apb_rsp.pready) begin
            rdata = apb_rsp.prdata;
            err   = apb_rsp.pslverr;
        end else begin
            $display("Timeout: PREADY stayed low for 10 cycles at address 0x%h", addr);
            n_timeout++;
        end
        @(negedge clk);
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
        apb_req.pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             output logic err);
        logic [31:0] unused;
        bus_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic apb_read(input logic [11:0] addr, output logic [31:0] data,
                            output logic err);
        bus_transfer(1'b0, addr, 32'd0, data, err);
    endtask

    task automatic load_program(input logic [7:0][15:0] prog);
        logic err;
        for (int k = 0; k < 8; k++) begin
            apb_write(cpu_bus_pkg::ADDR_IMEM_BASE + 12'(4 * k), {16'd0, prog[k]}, err);
            check("pslverr", err, 32'd0);
        end
    endtask

    task automatic run_program(input logic [7:0][15:0] prog);
        logic [31:0] data;
        logic        err;
        int          polls;
        load_program(prog);
        apb_write(cpu_bus_pkg::ADDR_CTRL, 32'd1, err);
        check("pslverr", err, 32'd0);
        data  = '0;
        polls = 0;
        while (!data[1] && polls < 200) begin
            apb_read(cpu_bus_pkg::ADDR_CTRL, data, err);
            polls++;
        end
        if (!data[1]) begin
            $display("Timeout: the core did not halt within %0d status polls", polls);
            n_timeout++;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic model_run(input logic [7:0][15:0] prog);
        logic [15:0] w;
        logic [15:0] a;
        logic [15:0] t;
        logic [15:0] res;
        logic [5:0]  next_pc;
        logic        done;
        int          steps;
        m_pc  = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 200) begin
            w = (m_pc < 6'd8) ? prog[m_pc[2:0]] : halt_word();
            a = m_d[w[8:6]];
            t = m_d[w[5:3]];
            next_pc = m_pc + 6'd1;
            case (w[15:12])
                cpu_isa_pkg::OP_NAND, cpu_isa_pkg::OP_ADD, cpu_isa_pkg::OP_SHR: begin
                    if (w[15:12] == cpu_isa_pkg::OP_NAND) begin
                        res = ~(a & t);
                    end else if (w[15:12] == cpu_isa_pkg::OP_ADD) begin
                        res = a + t;
                    end else begin
                        res = a >> t[3:0];
                    end
                    m_d[w[11:9]] = res;
                    m_s[w[2:1]]  = (res == 16'd0);
                end
                cpu_isa_pkg::OP_LDI: m_d[w[11:9]] = {7'd0, w[8:0]};
                cpu_isa_pkg::OP_LD:  m_d[w[11:9]] = m_mem[a[4:0]];
                cpu_isa_pkg::OP_ST:  m_mem[a[4:0]] = t;
                cpu_isa_pkg::OP_BR: begin
                    // Target is read before the link lands, even when rw equals rt.
                    if (m_s[w[5:4]] ^ w[0]) begin
                        next_pc = m_d[w[8:6]][5:0];
                    end
                    if (w[11:9] != 3'd0) begin
                        m_d[w[11:9]] = {10'd0, m_pc + 6'd1};
                    end
                end
                cpu_isa_pkg::OP_HALT: done = 1'b1;
                default: begin
                end
            endcase
            if (!done) begin
                m_pc = next_pc;
            end
            steps++;
        end
    endtask

    task automatic check_regs();
        logic [31:0] data;
        logic        err;
        for (int r = 0; r < 8; r++) begin
            apb_read(cpu_bus_pkg::ADDR_DREG_BASE + 12'(4 * r), data, err);
            check("pslverr", err, 32'd0);
            check($sformatf("r%0d", r), data, {16'd0, m_d[r]});
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        n_rst = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        n_rst = 1'b1;
        for (int r = 0; r < 8; r++) begin
            m_d[r] = '0;
        end
        for (int s = 0; s < 4; s++) begin
            m_s[s] = 1'b0;
        end
        for (int m = 0; m < 32; m++) begin
            m_mem[m] = '0;
        end
    endtask

    task automatic add_test(input logic [7:0][15:0] prog, input logic [2:0] reg_idx,
                            input logic [15:0] expected, input logic use_model);
        tests.push_back('{prog: prog, reg_idx: reg_idx, expected: expected,
                          use_model: use_model});
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus table
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic build_table();
        logic [7:0][15:0] p;
        logic [8:0]       v;
        p = {8{halt_word()}};
        p[0] = i_word(3'd1, next_imm());
        p[1] = i_word(3'd2, next_imm());
        p[2] = r_word(cpu_isa_pkg::OP_NAND, 3'd3, 3'd1, 3'd2, 2'd0);
        p[3] = r_word(cpu_isa_pkg::OP_ADD, 3'd4, 3'd1, 3'd2, 2'd1);
        p[4] = r_word(cpu_isa_pkg::OP_SHR, 3'd5, 3'd1, 3'd2, 2'd2);
        add_test(p, 3'd3, 16'd0, 1'b1);
        p = {8{halt_word()}};
        p[0] = i_word(3'd6, next_imm());
        p[1] = i_word(3'd7, next_imm());
        p[2] = r_word(cpu_isa_pkg::OP_ADD, 3'd1, 3'd6, 3'd7, 2'd3);
        p[3] = r_word(cpu_isa_pkg::OP_SHR, 3'd2, 3'd1, 3'd7, 2'd0);
        p[4] = r_word(cpu_isa_pkg::OP_NAND, 3'd3, 3'd1, 3'd2, 2'd1);
        add_test(p, 3'd2, 16'd0, 1'b1);
        // All ones in r1 takes two programs, since doubling 0x1ff needs seven ADDs.
        p = {8{halt_word()}};
        p[0] = i_word(3'd1, 9'h1ff);
        for (int k = 1; k < 7; k++) begin
            p[k] = r_word(cpu_isa_pkg::OP_ADD, 3'd1, 3'd1, 3'd1, 2'd0);
        end
        add_test(p, 3'd1, 16'h7fc0, 1'b0);
        p = {8{halt_word()}};
        p[0] = r_word(cpu_isa_pkg::OP_ADD, 3'd1, 3'd1, 3'd1, 2'd0);
        p[1] = i_word(3'd2, 9'h1ff);
        p[2] = i_word(3'd5, 9'd2);
        p[3] = r_word(cpu_isa_pkg::OP_SHR, 3'd2, 3'd2, 3'd5, 2'd0);
        p[4] = r_word(cpu_isa_pkg::OP_ADD, 3'd1, 3'd1, 3'd2, 2'd0);
        p[5] = r_word(cpu_isa_pkg::OP_NAND, 3'd3, 3'd1, 3'd1, 2'd3);
        add_test(p, 3'd3, 16'h0000, 1'b0);
        // Branch on the zero flag of an ADD, taken and then not taken.
        for (int inv = 0; inv < 2; inv++) begin
            p = {8{halt_word()}};
            p[0] = i_word(3'd3, 9'd5);
            p[1] = i_word(3'd4, 9'd0);
            p[2] = r_word(cpu_isa_pkg::OP_ADD, 3'd5, 3'd4, 3'd4, 2'd1);
            p[3] = b_word(3'd6, 3'd3, 2'd1, 1'(inv));
            p[4] = i_word(3'd7, next_imm());
            add_test(p, 3'd6, 16'd4, 1'b0);
            add_test(p, 3'd7, 16'd0, 1'b1);
        end
        v = next_imm();
        p = {8{halt_word()}};
        p[0] = i_word(3'd1, next_imm());
        p[1] = i_word(3'd2, v);
        p[2] = r_word(cpu_isa_pkg::OP_ST, 3'd0, 3'd1, 3'd2, 2'd0);
        p[3] = r_word(cpu_isa_pkg::OP_LD, 3'd4, 3'd1, 3'd0, 2'd0);
        add_test(p, 3'd4, {7'd0, v}, 1'b0);
        // Restarts keep registers, so r1 grows by one per run.
        p = {8{halt_word()}};
        p[0] = i_word(3'd1, 9'd5);
        p[1] = i_word(3'd2, 9'd1);
        add_test(p, 3'd1, 16'd5, 1'b0);
        p = {8{halt_word()}};
        p[0] = r_word(cpu_isa_pkg::OP_ADD, 3'd1, 3'd1, 3'd2, 2'd0);
        add_test(p, 3'd1, 16'd6, 1'b0);
        add_test(p, 3'd1, 16'd7, 1'b0);
    endtask

    task automatic check_bus_errors();
        logic [7:0][15:0] p;
        logic [31:0]      data;
        logic             err;
        apb_write(cpu_bus_pkg::ADDR_PC, 32'h3, err);
        check("pslverr", err, 32'd1);
        apb_read(cpu_bus_pkg::ADDR_PC, data, err);
        check("pc", data, {26'd0, m_pc});
        apb_read(cpu_bus_pkg::ADDR_IMEM_BASE, data, err);
        check("pslverr", err, 32'd1);
        check("prdata", data, 32'd0);
        apb_read(12'h020, data, err);
        check("pslverr", err, 32'd1);
        apb_write(cpu_bus_pkg::ADDR_DREG_BASE + 12'h4, 32'h1234, err);
        check("pslverr", err, 32'd1);
        check_regs();
        // The core spins on a branch to itself at word 2.
        p = {8{halt_word()}};
        p[0] = i_word(3'd1, 9'd2);
        p[1] = r_word(cpu_isa_pkg::OP_NAND, 3'd2, 3'd1, 3'd1, 2'd0);
        p[2] = b_word(3'd0, 3'd1, 2'd0, 1'b1);
        load_program(p);
        apb_write(cpu_bus_pkg::ADDR_CTRL, 32'd1, err);
        apb_write(cpu_bus_pkg::ADDR_IMEM_BASE + 12'h8, {16'd0, halt_word()}, err);
        check("pslverr", err, 32'd1);
        for (int k = 0; k < 4; k++) begin
            apb_read(cpu_bus_pkg::ADDR_CTRL, data, err);
            check("ctrl", data, 32'd1);
        end
        apb_read(cpu_bus_pkg::ADDR_PC, data, err);
        check("pc", data, 32'd2);
    endtask

    initial begin
        logic [31:0] data;
        logic        err;
        logic [15:0] exp;
        clk        = 1'b0;
        n_rst      = 1'b0;
        apb_req    = '0;
        rng        = 32'hfefd;
        n_checks   = 0;
        n_mismatch = 0;
        n_timeout  = 0;
        apply_reset();

        apb_read(cpu_bus_pkg::ADDR_CTRL, data, err);
        check("ctrl", data, 32'd0);
        apb_read(cpu_bus_pkg::ADDR_PC, data, err);
        check("pc", data, 32'd0);
        check_regs();

        build_table();
        for (int i = 0; i < tests.size(); i++) begin
            model_run(tests[i].prog);
            run_program(tests[i].prog);
            apb_read(cpu_bus_pkg::ADDR_PC, data, err);
            check("pc", data, {26'd0, m_pc});
            exp = tests[i].use_model ? m_d[tests[i].reg_idx] : tests[i].expected;
            apb_read(cpu_bus_pkg::ADDR_DREG_BASE + 12'(4 * tests[i].reg_idx), data, err);
            check($sformatf("r%0d", tests[i].reg_idx), data, {16'd0, exp});
            check_regs();
        end

        check_bus_errors();
        apply_reset();
        apb_read(cpu_bus_pkg::ADDR_CTRL, data, err);
        check("ctrl", data, 32'd0);

        $display("Checks: %0d, mismatches: %0d, timeouts: %0d",
                 n_checks, n_mismatch, n_timeout);
        if (n_mismatch == 0 && n_timeout == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

// ==== build.f ====
design/cpu_isa_pkg.sv
design/cpu_bus_pkg.sv
design/regfile.sv
design/exec_unit.sv
design/branch_unit.sv
design/mem_unit.sv
design/issue_ctrl.sv
design/host_apb.sv
design/nand_cpu.sv
test/nand_cpu_tb.sv

// ==== Bender.yml ====
package:
  name: nand_cpu

sources:
  - design/cpu_isa_pkg.sv
  - design/cpu_bus_pkg.sv
  - design/regfile.sv
  - design/exec_unit.sv
  - design/branch_unit.sv
  - design/mem_unit.sv
  - design/issue_ctrl.sv
  - design/host_apb.sv
  - design/nand_cpu.sv
  - target: test
    files:
      - test/nand_cpu_tb.sv
